//--- all.f
+incdir+hdl
+incdir+verif
hdl/sac_pkg.sv
hdl/sac_infer_if.sv
hdl/sac_dense_layer.sv
hdl/sac_output_stage.sv
hdl/sac_network.sv
hdl/sac_apb_regs.sv
hdl/sac_top.sv
verif/tb_sac_top.sv

//--- Makefile
SRCS := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv verif/*.svh)

.PHONY: all run clean

all: obj_dir/Vtb_sac_top

# rebuilt only when a source or the file list changes
obj_dir/Vtb_sac_top: all.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_sac_top -f all.f

# the simulator exits nonzero on $fatal
run: obj_dir/Vtb_sac_top
	./obj_dir/Vtb_sac_top

clean:
	rm -rf obj_dir

//--- verif/sac_ref_model.svh
`ifndef SAC_REF_MODEL_SVH
`define SAC_REF_MODEL_SVH

// lcg step, 32-bit state
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// a -1 weight is the ones' complement of the input
function automatic act_t weigh(input act_t a, input logic neg);
    return neg ? ~a : a;
endfunction

function automatic act_t relu(input act_t s);
    if (s[15])
        return '0;
    return s;
endfunction

// knees belong to the upper region
function automatic act_t sigmoid(input act_t s);
    if (s < 16'h0400)
        return (s >> 2) + 16'h0200;
    if (s < 16'h0980)
        return (s >> 3) + 16'h0280;
    if (s < 16'h1400)
        return (s >> 5) + 16'h0360;
    return 16'h0400;
endfunction

function automatic logic model_class(input act_t score);
    return score > 16'h0200;
endfunction

// 2-8-12-6-4-1 network, all sums wrap mod 2^16
function automatic act_t model_score(input act_t x1, input act_t x2);
    act_t a0 [2];
    act_t a1 [8];
    act_t a2 [12];
    act_t a3 [6];
    act_t a4 [4];
    act_t sum;
    a0[0] = x1;
    a0[1] = x2;
    for (int n = 0; n < 8; n++)
    begin
        sum = '0;
        for (int j = 0; j < 2; j++)
            sum = sum + weigh(a0[j], L1_SIGN[n][j]);
        a1[n] = relu(sum);
    end
    for (int n = 0; n < 12; n++)
    begin
        sum = '0;
        for (int j = 0; j < 8; j++)
            sum = sum + weigh(a1[j], L2_SIGN[n][j]);
        a2[n] = relu(sum);
    end
    for (int n = 0; n < 6; n++)
    begin
        sum = '0;
        for (int j = 0; j < 12; j++)
            sum = sum + weigh(a2[j], L3_SIGN[n][j]);
        a3[n] = relu(sum);
    end
    for (int n = 0; n < 4; n++)
    begin
        sum = '0;
        for (int j = 0; j < 6; j++)
            sum = sum + weigh(a3[j], L4_SIGN[n][j]);
        a4[n] = relu(sum);
    end
    // output neuron, no relu
    sum = '0;
    for (int j = 0; j < 4; j++)
        sum = sum + weigh(a4[j], OUT_SIGN[0][j]);
    return sigmoid(sum);
endfunction

`endif

//--- verif/tb_sac_top.sv
`timescale 1ns/1ps

`include "sac_defines.svh"

module tb_sac_top;
    import sac_pkg::*;

    `include "sac_ref_model.svh"

    localparam int N_DIRECTED = 11;
    localparam int N_RANDOM = 200;
    // one inference is about 16 bus cycles
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM + 3) * 20 + 500;

    // with x2 = 0 the output sum steps by 16 per x1, straddling each knee
    localparam act_t DIR_X1 [N_DIRECTED] = '{16'd0, 16'd21, 16'd68, 16'd69, 16'd156,
        16'd157, 16'd324, 16'd325, 16'd1000, 16'd0, 16'hFFFF};
    localparam act_t DIR_X2 [N_DIRECTED] = '{16'd0, 16'd0, 16'd0, 16'd0, 16'd0,
        16'd0, 16'd0, 16'd0, 16'd0, 16'd50, 16'hFFFF};

    logic clk;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic pready;
    logic pslverr;
    logic exp_err;
    logic chk_rd;
    apb_data_t exp_rdata;
    logic [31:0] lcg_state;
    logic acc;
    logic start_acc;

    assign acc = psel & penable;
    assign start_acc = acc & pwrite & (paddr == `SAC_ADDR_CTRL) & pwdata[0] & !exp_err;

    sac_top uut (
        .clk,
        .rst,
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .paddr_i(paddr),
        .pwdata_i(pwdata),
        .prdata_o(prdata),
        .pready_o(pready),
        .pslverr_o(pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        (acc && !pwrite && chk_rd) |-> prdata == exp_rdata)
        else abort_run($sformatf("MISMATCH prdata_o addr %h got %h expected %h",
            $sampled(paddr), $sampled(prdata), $sampled(exp_rdata)));
    a_slverr: assert property (@(posedge clk) disable iff (rst)
        pslverr == (acc && exp_err))
        else abort_run($sformatf("MISMATCH pslverr_o addr %h got %h expected %h",
            $sampled(paddr), $sampled(pslverr), $sampled(acc && exp_err)));
    a_ready: assert property (@(posedge clk) disable iff (rst) acc |-> pready)
        else abort_run("pready_o was low in an access phase");
    // busy from the cycle after the CTRL access until 7 cycles after it
    a_busy_rise: assert property (@(posedge clk) disable iff (rst)
        $past(start_acc) |-> uut.u_regs.busy)
        else abort_run($sformatf("MISMATCH busy got %h expected 1", $sampled(uut.u_regs.busy)));
    a_busy_hold: assert property (@(posedge clk) disable iff (rst)
        $past(start_acc, 7) |-> uut.u_regs.busy)
        else abort_run($sformatf("MISMATCH busy got %h expected 1", $sampled(uut.u_regs.busy)));
    a_busy_fall: assert property (@(posedge clk) disable iff (rst)
        $past(start_acc, 8) |-> !uut.u_regs.busy)
        else abort_run($sformatf("MISMATCH busy got %h expected 0", $sampled(uut.u_regs.busy)));
    a_busy_origin: assert property (@(posedge clk) disable iff (rst)
        $fell(uut.u_regs.busy) |-> $past(start_acc, 8))
        else abort_run("busy cleared without a start accepted 7 cycles earlier");

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("timeout, the tests did not finish before the watchdog expired");
    end

    // called on a falling edge, returns on a falling edge
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        exp_err = err;
        chk_rd = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        exp_err = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input logic check, input apb_data_t exp,
                            input logic err, output apb_data_t data);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        exp_err = err;
        chk_rd = check;
        exp_rdata = exp;
        @(negedge clk);
        penable = 1'b1;
        #2 data = prdata;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        exp_err = 1'b0;
        chk_rd = 1'b0;
    endtask

    task automatic read_expect(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t rd;
        apb_read(addr, 1'b1, exp, 1'b0, rd);
    endtask

    task automatic wait_idle();
        apb_data_t st;
        st = 32'd1;
        while (st[0])
            apb_read(`SAC_ADDR_STATUS, 1'b0, '0, 1'b0, st);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic check_cleared();
        read_expect(`SAC_ADDR_STATUS, 32'd0);
        read_expect(`SAC_ADDR_SCORE, 32'd0);
        read_expect(`SAC_ADDR_INPUT, 32'd0);
    endtask

    task automatic check_result(input act_t x1, input act_t x2);
        act_t s;
        s = model_score(x1, x2);
        read_expect(`SAC_ADDR_SCORE, {16'd0, s});
        read_expect(`SAC_ADDR_STATUS, {30'd0, model_class(s), 1'b0});
    endtask

    task automatic run_inference(input act_t x1, input act_t x2);
        apb_write(`SAC_ADDR_INPUT, {x2, x1}, 1'b0);
        apb_write(`SAC_ADDR_CTRL, 32'd1, 1'b0);
        wait_idle();
        check_result(x1, x2);
    endtask

    task automatic check_protocol_errors();
        apb_data_t rd;
        apb_write(`SAC_ADDR_INPUT, {16'd3, 16'd100}, 1'b0);
        apb_write(`SAC_ADDR_CTRL, 32'd1, 1'b0);
        // start while busy, then bad offsets and directions
        apb_write(`SAC_ADDR_CTRL, 32'd1, 1'b1);
        apb_write(8'h10, 32'hFFFF_FFFF, 1'b1);
        apb_read(8'h14, 1'b0, '0, 1'b1, rd);
        apb_write(`SAC_ADDR_STATUS, 32'h3, 1'b1);
        apb_read(`SAC_ADDR_CTRL, 1'b0, '0, 1'b1, rd);
        wait_idle();
        check_result(16'd100, 16'd3);
        apb_write(`SAC_ADDR_SCORE, 32'h1234, 1'b1);
        apb_write(8'h01, 32'hFFFF_FFFF, 1'b1);
        check_result(16'd100, 16'd3);
        read_expect(`SAC_ADDR_INPUT, {16'd3, 16'd100});
    endtask

    initial
    begin
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        exp_err = 1'b0;
        chk_rd = 1'b0;
        exp_rdata = '0;
        lcg_state = 32'd96483;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_cleared();

        for (int i = 0; i < N_DIRECTED; i++)
            run_inference(DIR_X1[i], DIR_X2[i]);
        // zero input sits at the sigmoid midpoint
        run_inference(16'd0, 16'd0);
        read_expect(`SAC_ADDR_SCORE, 32'h0000_0200);

        for (int i = 0; i < N_RANDOM; i++)
        begin
            act_t x1;
            act_t x2;
            lcg_state = lcg_next(lcg_state);
            x1 = lcg_state[31:16];
            lcg_state = lcg_next(lcg_state);
            x2 = lcg_state[31:16];
            run_inference(x1, x2);
        end

        check_protocol_errors();

        // reset in the middle of an inference
        apb_write(`SAC_ADDR_INPUT, {16'd0, 16'd500}, 1'b0);
        apb_write(`SAC_ADDR_CTRL, 32'd1, 1'b0);
        repeat (3) @(negedge clk);
        apply_reset();
        check_cleared();

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- hdl/sac_top.sv
`timescale 1ns/1ps

module sac_top (
    input  logic clk,
    input  logic rst,
    input  logic psel_i,
    input  logic penable_i,
    input  logic pwrite_i,
    input  sac_pkg::apb_addr_t paddr_i,
    input  sac_pkg::apb_data_t pwdata_i,
    output sac_pkg::apb_data_t prdata_o,
    output logic pready_o,
    output logic pslverr_o
);

    // register block to network link
    sac_infer_if infer_bus ();

    sac_apb_regs u_regs (
        .clk,
        .rst,
        .psel_i,
        .penable_i,
        .pwrite_i,
        .paddr_i,
        .pwdata_i,
        .prdata_o,
        .pready_o,
        .pslverr_o,
        .bus(infer_bus.regs)
    );

    sac_network u_net (
        .clk,
        .rst,
        .bus(infer_bus.core)
    );

endmodule

//--- hdl/sac_apb_regs.sv
`timescale 1ns/1ps

`include "sac_defines.svh"

module sac_apb_regs (
    input  logic clk,
    input  logic rst,
    input  logic psel_i,
    input  logic penable_i,
    input  logic pwrite_i,
    input  sac_pkg::apb_addr_t paddr_i,
    input  sac_pkg::apb_data_t pwdata_i,
    output sac_pkg::apb_data_t prdata_o,
    output logic pready_o,
    output logic pslverr_o,
    sac_infer_if.regs bus
);
    import sac_pkg::*;

    ctrl_state_e state_q;
    act_t x1_q;
    act_t x2_q;
    act_t score_q;
    logic class_q;
    logic start_q;
    logic busy;
    logic access;
    logic bad_access;
    logic start_req;
    logic start_err;

    // no wait states, every transfer ends in its access phase
    assign pready_o = 1'b1;
    assign access = psel_i & penable_i;
    // busy already in the start pulse cycle
    assign busy = start_q | (state_q == BUSY);

    // read mux and direction check
    always_comb
    begin
        prdata_o = '0;
        bad_access = 1'b0;
        case (paddr_i)
            `SAC_ADDR_INPUT: prdata_o = {x2_q, x1_q};
            `SAC_ADDR_CTRL: bad_access = !pwrite_i;
            `SAC_ADDR_STATUS:
            begin
                prdata_o = {30'd0, class_q, busy};
                bad_access = pwrite_i;
            end
            `SAC_ADDR_SCORE:
            begin
                prdata_o = {16'd0, score_q};
                bad_access = pwrite_i;
            end
            default: bad_access = 1'b1;
        endcase
    end

    assign start_req = access & pwrite_i & (paddr_i == `SAC_ADDR_CTRL) & pwdata_i[0];
    assign start_err = start_req & busy;
    assign pslverr_o = access & (bad_access | start_err);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= IDLE;
            start_q <= 1'b0;
            x1_q <= '0;
            x2_q <= '0;
            score_q <= '0;
            class_q <= 1'b0;
        end
        else
        begin
            start_q <= start_req & !busy;
            if (access && pwrite_i && paddr_i == `SAC_ADDR_INPUT)
            begin
                x1_q <= pwdata_i[`SAC_DATA_W-1:0];
                x2_q <= pwdata_i[2*`SAC_DATA_W-1:`SAC_DATA_W];
            end
            case (state_q)
                IDLE:
                    if (start_q)
                        state_q <= BUSY;
                BUSY:
                    if (bus.done)
                    begin
                        // result is only valid in the done cycle
                        state_q <= IDLE;
                        score_q <= bus.score;
                        class_q <= bus.class_bit;
                    end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign bus.start = start_q;
    assign bus.x1 = x1_q;
    assign bus.x2 = x2_q;

    a_no_wait: assert property (@(posedge clk) disable iff (rst)
        access |-> pready_o);
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        bus.start |-> state_q == IDLE);

endmodule

//--- hdl/sac_network.sv
`timescale 1ns/1ps

`include "sac_defines.svh"

module sac_network (
    input logic clk,
    input logic rst,
    sac_infer_if.core bus
);
    import sac_pkg::*;

    act_t [`SAC_N_IN-1:0] l0_act;
    act_t [`SAC_N_L1-1:0] l1_act;
    act_t [`SAC_N_L2-1:0] l2_act;
    act_t [`SAC_N_L3-1:0] l3_act;
    act_t [`SAC_N_L4-1:0] l4_act;
    act_t [0:0] l5_act;
    logic l1_valid;
    logic l2_valid;
    logic l3_valid;
    logic l4_valid;
    logic l5_valid;

    // x1 is input 1
    assign l0_act = {bus.x2, bus.x1};

    sac_dense_layer #(.N_IN(`SAC_N_IN), .N_OUT(`SAC_N_L1), .SIGN(L1_SIGN), .USE_RELU(1'b1))
        u_l1 (.clk, .rst, .in_valid_i(bus.start), .in_act_i(l0_act),
              .out_valid_o(l1_valid), .out_act_o(l1_act));

    sac_dense_layer #(.N_IN(`SAC_N_L1), .N_OUT(`SAC_N_L2), .SIGN(L2_SIGN), .USE_RELU(1'b1))
        u_l2 (.clk, .rst, .in_valid_i(l1_valid), .in_act_i(l1_act),
              .out_valid_o(l2_valid), .out_act_o(l2_act));

    sac_dense_layer #(.N_IN(`SAC_N_L2), .N_OUT(`SAC_N_L3), .SIGN(L3_SIGN), .USE_RELU(1'b1))
        u_l3 (.clk, .rst, .in_valid_i(l2_valid), .in_act_i(l2_act),
              .out_valid_o(l3_valid), .out_act_o(l3_act));

    sac_dense_layer #(.N_IN(`SAC_N_L3), .N_OUT(`SAC_N_L4), .SIGN(L4_SIGN), .USE_RELU(1'b1))
        u_l4 (.clk, .rst, .in_valid_i(l3_valid), .in_act_i(l3_act),
              .out_valid_o(l4_valid), .out_act_o(l4_act));

    // output neuron is a plain sum, no relu
    sac_dense_layer #(.N_IN(`SAC_N_L4), .N_OUT(1), .SIGN(OUT_SIGN), .USE_RELU(1'b0))
        u_out (.clk, .rst, .in_valid_i(l4_valid), .in_act_i(l4_act),
               .out_valid_o(l5_valid), .out_act_o(l5_act));

    sac_output_stage u_sig (
        .clk,
        .rst,
        .in_valid_i(l5_valid),
        .in_sum_i(l5_act[0]),
        .out_valid_o(bus.done),
        .score_o(bus.score),
        .class_o(bus.class_bit)
    );

    a_start_to_done: assert property (@(posedge clk) disable iff (rst)
        bus.start |-> ##(`SAC_LATENCY) bus.done);
    a_done_from_start: assert property (@(posedge clk) disable iff (rst)
        bus.done |-> $past(bus.start, `SAC_LATENCY));

endmodule

//--- hdl/sac_output_stage.sv
`timescale 1ns/1ps

`include "sac_defines.svh"

module sac_output_stage (
    input  logic clk,
    input  logic rst,
    input  logic in_valid_i,
    input  sac_pkg::act_t in_sum_i,
    output logic out_valid_o,
    output sac_pkg::act_t score_o,
    output logic class_o
);
    import sac_pkg::*;

    act_t score_c;
    logic class_c;

    // piecewise sigmoid, each knee belongs to the upper region
    always_comb
    begin
        if (in_sum_i < `SAC_SIG_KNEE0)
            score_c = (in_sum_i >> 2) + `SAC_SIG_OFF0;
        else if (in_sum_i < `SAC_SIG_KNEE1)
            score_c = (in_sum_i >> 3) + `SAC_SIG_OFF1;
        else if (in_sum_i < `SAC_SIG_KNEE2)
            score_c = (in_sum_i >> 5) + `SAC_SIG_OFF2;
        else
            score_c = `SAC_SIG_SAT;
    end

    // a score equal to the threshold stays class 0
    assign class_c = (score_c > `SAC_CLASS_THRESH);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid_o <= 1'b0;
            score_o <= '0;
            class_o <= 1'b0;
        end
        else
        begin
            out_valid_o <= in_valid_i;
            score_o <= score_c;
            class_o <= class_c;
        end
    end

endmodule

//--- hdl/sac_dense_layer.sv
`timescale 1ns/1ps

`include "sac_defines.svh"

module sac_dense_layer #(
    parameter int N_IN = 2,
    parameter int N_OUT = 8,
    parameter logic [0:N_OUT-1][N_IN-1:0] SIGN = '0,
    parameter bit USE_RELU = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid_i,
    input  sac_pkg::act_t [N_IN-1:0] in_act_i,
    output logic out_valid_o,
    output sac_pkg::act_t [N_OUT-1:0] out_act_o
);
    import sac_pkg::*;

    act_t [N_OUT-1:0] sum_c;
    act_t [N_OUT-1:0] act_c;

    // a -1 weight is the ones' complement of the input
    // sums wrap modulo 2^16
    always_comb
    begin
        for (int n = 0; n < N_OUT; n++)
        begin
            sum_c[n] = '0;
            for (int j = 0; j < N_IN; j++)
            begin
                if (SIGN[n][j])
                    sum_c[n] = sum_c[n] + ~in_act_i[j];
                else
                    sum_c[n] = sum_c[n] + in_act_i[j];
            end
            // relu clamps anything with the sign bit set
            if (USE_RELU && sum_c[n][`SAC_DATA_W-1])
                act_c[n] = '0;
            else
                act_c[n] = sum_c[n];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            out_valid_o <= 1'b0;
        else
            out_valid_o <= in_valid_i;
    end

    always_ff @(posedge clk)
    begin
        out_act_o <= act_c;
    end

    if (USE_RELU)
    begin : g_relu_chk
        for (genvar n = 0; n < N_OUT; n++)
        begin : g_neuron
            a_relu_nonneg: assert property (@(posedge clk) disable iff (rst)
                out_valid_o |-> !out_act_o[n][`SAC_DATA_W-1]);
        end
    end

endmodule

//--- hdl/sac_infer_if.sv
`timescale 1ns/1ps

interface sac_infer_if;
    import sac_pkg::*;

    logic start;
    act_t x1;
    act_t x2;
    logic done;
    act_t score;
    logic class_bit;

    // register block side
    modport regs (
        output start, x1, x2,
        input  done, score, class_bit
    );

    // network side
    modport core (
        input  start, x1, x2,
        output done, score, class_bit
    );

endinterface

//--- hdl/sac_pkg.sv
`include "sac_defines.svh"

package sac_pkg;

    typedef logic [`SAC_DATA_W-1:0] act_t;
    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic {
        IDLE,
        BUSY
    } ctrl_state_e;

    // one entry per neuron, neuron 1 leftmost (index 0)
    // bit j set means input j+1 is negated
    localparam logic [0:`SAC_N_L1-1][`SAC_N_IN-1:0] L1_SIGN = {
        2'b11, 2'b11, 2'b10, 2'b01,
        2'b01, 2'b11, 2'b01, 2'b01
    };

    localparam logic [0:`SAC_N_L2-1][`SAC_N_L1-1:0] L2_SIGN = {
        8'b1001_1010, 8'b0010_1110, 8'b1101_1010, 8'b0000_1110,
        8'b1101_0000, 8'b0111_0001, 8'b0110_1101, 8'b0000_0111,
        8'b0011_0000, 8'b1101_0000, 8'b0011_0110, 8'b0001_1000
    };

    localparam logic [0:`SAC_N_L3-1][`SAC_N_L2-1:0] L3_SIGN = {
        12'b0000_1101_1011, 12'b0000_1101_1001, 12'b1010_0110_1101,
        12'b1110_0010_0010, 12'b0000_1000_0111, 12'b0011_0011_0011
    };

    localparam logic [0:`SAC_N_L4-1][`SAC_N_L3-1:0] L4_SIGN = {
        6'b111111, 6'b111111, 6'b101100, 6'b101100
    };

    // output neuron only adds
    localparam logic [0:0][`SAC_N_L4-1:0] OUT_SIGN = 4'b0000;

endpackage

//--- hdl/sac_defines.svh
`ifndef SAC_DEFINES_SVH
`define SAC_DEFINES_SVH

// activation width and layer sizes
`define SAC_DATA_W 16
`define SAC_N_IN 2
`define SAC_N_L1 8
`define SAC_N_L2 12
`define SAC_N_L3 6
`define SAC_N_L4 4

// sigmoid region bounds, offsets and saturation
`define SAC_SIG_KNEE0 16'h0400
`define SAC_SIG_KNEE1 16'h0980
`define SAC_SIG_KNEE2 16'h1400
`define SAC_SIG_OFF0 16'h0200
`define SAC_SIG_OFF1 16'h0280
`define SAC_SIG_OFF2 16'h0360
`define SAC_SIG_SAT 16'h0400
`define SAC_CLASS_THRESH 16'h0200

// register offsets
`define SAC_ADDR_INPUT 8'h00
`define SAC_ADDR_CTRL 8'h04
`define SAC_ADDR_STATUS 8'h08
`define SAC_ADDR_SCORE 8'h0C

// start pulse to done, in cycles
`define SAC_LATENCY 6

`endif
